//--- src/fft_num_pkg.sv
`default_nettype none

package fft_num_pkg;

    localparam int data_w_c        = 5;   // input component
    localparam int acc_w_c         = 12;  // internal component, room for growth
    localparam int out_w_c         = 10;  // result component
    localparam int twiddle_w_c     = 5;

    // twiddles hold cos and sin times ten
    localparam int twiddle_scale_c = 10;

    typedef struct packed {
        logic signed [twiddle_w_c-1:0] re;
        logic signed [twiddle_w_c-1:0] im;
    } twiddle_t;

    typedef struct packed {
        logic signed [data_w_c-1:0] re;
        logic signed [data_w_c-1:0] im;
    } cplx_in_t;

    typedef struct packed {
        logic signed [acc_w_c-1:0] re;
        logic signed [acc_w_c-1:0] im;
    } cplx_acc_t;

    typedef struct packed {
        logic signed [out_w_c-1:0] re;
        logic signed [out_w_c-1:0] im;
    } cplx_out_t;

    // one lane per point, lane 0 in the low bits
    typedef cplx_in_t  [7:0] frame_in_t;
    typedef cplx_acc_t [7:0] frame_acc_t;
    typedef cplx_out_t [7:0] frame_out_t;

endpackage

`default_nettype wire

//--- src/fft_geom_pkg.sv
`default_nettype none

package fft_geom_pkg;

    import fft_num_pkg::*;

    localparam int fft_n_c      = 8;
    localparam int fft_stages_c = 3;  // log2 of fft_n_c

    // lane i of the first stage takes input point bitrev_c[i]
    localparam int bitrev_c [fft_n_c] = '{0, 4, 2, 6, 1, 5, 3, 7};

    // W8^k = cos(2 pi k / 8) - j sin(2 pi k / 8), scaled by ten
    localparam twiddle_t twiddle_rom_c [fft_n_c/2] = '{
        twiddle_t'{re:  5'sd10, im:  5'sd0},   // k = 0
        twiddle_t'{re:  5'sd7,  im: -5'sd7},   // k = 1
        twiddle_t'{re:  5'sd0,  im: -5'sd10},  // k = 2
        twiddle_t'{re: -5'sd7,  im: -5'sd7}    // k = 3
    };

endpackage

`default_nettype wire

//--- src/fft_cmul_scaled.sv
`default_nettype none
`timescale 1ns/100ps

module fft_cmul_scaled #(
    parameter int ACC_W = fft_num_pkg::acc_w_c
) (
    input  fft_num_pkg::cplx_acc_t a,
    input  fft_num_pkg::twiddle_t  w,
    output fft_num_pkg::cplx_acc_t p
);

    import fft_num_pkg::*;

    localparam int PROD_W = ACC_W + twiddle_w_c;

    typedef struct packed {
        logic signed [ACC_W-1:0] re;
        logic signed [ACC_W-1:0] im;
    } cplx_t;

    cplx_t a_v;
    cplx_t p_v;

    logic signed [PROD_W-1:0] re_re;
    logic signed [PROD_W-1:0] im_im;
    logic signed [PROD_W-1:0] re_im;
    logic signed [PROD_W-1:0] im_re;

    logic signed [PROD_W-1:0] q_re_re;
    logic signed [PROD_W-1:0] q_im_im;
    logic signed [PROD_W-1:0] q_re_im;
    logic signed [PROD_W-1:0] q_im_re;

    assign a_v = a;

    assign re_re = PROD_W'(a_v.re) * PROD_W'(w.re);
    assign im_im = PROD_W'(a_v.im) * PROD_W'(w.im);
    assign re_im = PROD_W'(a_v.re) * PROD_W'(w.im);
    assign im_re = PROD_W'(a_v.im) * PROD_W'(w.re);

    // each product scaled back on its own and truncated toward zero
    assign q_re_re = re_re / PROD_W'(twiddle_scale_c);
    assign q_im_im = im_im / PROD_W'(twiddle_scale_c);
    assign q_re_im = re_im / PROD_W'(twiddle_scale_c);
    assign q_im_re = im_re / PROD_W'(twiddle_scale_c);

    assign p_v.re = ACC_W'(q_re_re - q_im_im);
    assign p_v.im = ACC_W'(q_re_im + q_im_re);

    assign p = p_v;

endmodule

`default_nettype wire

//--- src/fft_input_reorder.sv
`default_nettype none
`timescale 1ns/100ps

module fft_input_reorder #(
    parameter int DATA_W = fft_num_pkg::data_w_c,
    parameter int ACC_W  = fft_num_pkg::acc_w_c
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fft_num_pkg::frame_in_t  sample,
    output fft_num_pkg::frame_acc_t frame
);

    import fft_geom_pkg::*;

    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_in_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] re;
        logic signed [ACC_W-1:0] im;
    } cplx_t;

    cplx_in_t [fft_n_c-1:0] sample_v;
    cplx_t    [fft_n_c-1:0] widened;
    cplx_t    [fft_n_c-1:0] frame_q;

    assign sample_v = sample;

    // sign extend and pick the bit-reversed source lane
    for (genvar i = 0; i < fft_n_c; i++) begin : g_lane
        assign widened[i].re = ACC_W'(sample_v[bitrev_c[i]].re);
        assign widened[i].im = ACC_W'(sample_v[bitrev_c[i]].im);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_q <= '0;
        end else begin
            frame_q <= widened;  // sampled every cycle
        end
    end

    assign frame = frame_q;

endmodule

`default_nettype wire

//--- src/fft_radix2_stage.sv
`default_nettype none
`timescale 1ns/100ps

module fft_radix2_stage #(
    parameter int ACC_W = fft_num_pkg::acc_w_c,
    parameter int STAGE = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fft_num_pkg::frame_acc_t frame_in,
    output fft_num_pkg::frame_acc_t frame_out
);

    import fft_geom_pkg::*;

    // pair distance, and twiddle index step between neighbouring pairs
    localparam int SPAN   = 1 << STAGE;
    localparam int K_STEP = (fft_n_c / 2) / SPAN;

    typedef struct packed {
        logic signed [ACC_W-1:0] re;
        logic signed [ACC_W-1:0] im;
    } cplx_t;

    cplx_t [fft_n_c-1:0] lane_in;
    cplx_t [fft_n_c-1:0] rot_d;
    cplx_t [fft_n_c-1:0] rot_q;
    cplx_t [fft_n_c-1:0] bfly_d;
    cplx_t [fft_n_c-1:0] bfly_q;

    assign lane_in = frame_in;

    for (genvar p = 0; p < fft_n_c / 2; p++) begin : g_pair
        localparam int LO = (p / SPAN) * 2 * SPAN + (p % SPAN);
        localparam int HI = LO + SPAN;
        localparam int K  = (p % SPAN) * K_STEP;

        // upper lane gets the twiddle, lower lane passes
        fft_cmul_scaled #(
            .ACC_W(ACC_W)
        ) cmul_i (
            .a(lane_in[HI]),
            .w(twiddle_rom_c[K]),
            .p(rot_d[HI])
        );

        assign rot_d[LO] = lane_in[LO];

        assign bfly_d[LO].re = rot_q[LO].re + rot_q[HI].re;
        assign bfly_d[LO].im = rot_q[LO].im + rot_q[HI].im;
        assign bfly_d[HI].re = rot_q[LO].re - rot_q[HI].re;
        assign bfly_d[HI].im = rot_q[LO].im - rot_q[HI].im;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rot_q  <= '0;
            bfly_q <= '0;
        end else begin
            rot_q  <= rot_d;   // step one, rotation
            bfly_q <= bfly_d;  // step two, add and subtract
        end
    end

    assign frame_out = bfly_q;

endmodule

`default_nettype wire

//--- src/fft8_top.sv
`default_nettype none
`timescale 1ns/100ps

module fft8_top #(
    parameter int DATA_W = fft_num_pkg::data_w_c,
    parameter int ACC_W  = fft_num_pkg::acc_w_c,
    parameter int OUT_W  = fft_num_pkg::out_w_c
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fft_num_pkg::frame_in_t  sample,
    output fft_num_pkg::frame_out_t result
);

    import fft_geom_pkg::*;

    typedef struct packed {
        logic signed [ACC_W-1:0] re;
        logic signed [ACC_W-1:0] im;
    } cplx_t;

    typedef struct packed {
        logic signed [OUT_W-1:0] re;
        logic signed [OUT_W-1:0] im;
    } cplx_out_t;

    typedef cplx_t [fft_n_c-1:0] frame_t;

    // entry 0 from the reorder block, entry s+1 from stage s
    frame_t                   stage_frame [fft_stages_c+1];
    cplx_out_t [fft_n_c-1:0]  result_v;

    fft_input_reorder #(
        .DATA_W(DATA_W),
        .ACC_W (ACC_W)
    ) reorder_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sample(sample),
        .frame (stage_frame[0])
    );

    for (genvar s = 0; s < fft_stages_c; s++) begin : g_stage
        fft_radix2_stage #(
            .ACC_W(ACC_W),
            .STAGE(s)
        ) stage_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .frame_in (stage_frame[s]),
            .frame_out(stage_frame[s+1])
        );
    end

    // magnitude stays below 2^(OUT_W-1), upper bits are sign copies
    for (genvar i = 0; i < fft_n_c; i++) begin : g_narrow
        assign result_v[i].re = OUT_W'(stage_frame[fft_stages_c][i].re);
        assign result_v[i].im = OUT_W'(stage_frame[fft_stages_c][i].im);
    end

    assign result = result_v;

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    input  logic hold_reset,  // extra reset request from the test
    output logic clk,
    output logic rst_n
);

    logic por_n;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // power-on reset, released on a rising edge
    initial begin
        por_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        por_n <= 1'b1;
    end

    assign rst_n = por_n & ~hold_reset;

endmodule

`default_nettype wire

//--- tests/tb_fft8.sv
`default_nettype none
`timescale 1ns/100ps

module tb_fft8;

    import fft_num_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        hold_reset;
    frame_in_t   sample;
    frame_out_t  result;

    frame_out_t  exp_q [$];  // expected frames in drive order
    int          due_q [$];  // edge count at which each one sits on result
    int          rd_idx;
    int          skip_to;
    int          edge_cnt;
    int          pipe_err;
    int          pipe_checks;
    int          pipe_bad;
    int          direct_err;
    int          direct_checks;
    logic [15:0] lfsr_state;

    tb_clock_gen #(
        .PERIOD_NS   (20),
        .RESET_CYCLES(4)
    ) clock_i (
        .hold_reset(hold_reset),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    fft8_top #(
        .DATA_W(data_w_c),
        .ACC_W (acc_w_c),
        .OUT_W (out_w_c)
    ) dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .sample(sample),
        .result(result)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // result is stable at the falling edge
    always @(negedge clk) begin
        if (rd_idx < skip_to) begin
            rd_idx = skip_to;  // frames dropped by a reset
        end
        if (rd_idx < exp_q.size()) begin
            if (due_q[rd_idx] < edge_cnt) begin
                $display("frame %0d passed its output cycle without a compare", rd_idx);
                pipe_err = pipe_err + 1;
                rd_idx = rd_idx + 1;
            end else if (due_q[rd_idx] == edge_cnt) begin
                compare_frame(result, exp_q[rd_idx], pipe_bad);
                pipe_err = pipe_err + pipe_bad;
                pipe_checks = pipe_checks + 1;
                rd_idx = rd_idx + 1;
            end
        end
    end

    task automatic compare_lane(input string name, input cplx_out_t got,
                                input cplx_out_t want, output int bad);
        bad = 0;
        if (got.re !== want.re) begin
            $display("error at %0t: %s.re = %0d, expected %0d", $time, name, got.re, want.re);
            bad++;
        end
        if (got.im !== want.im) begin
            $display("error at %0t: %s.im = %0d, expected %0d", $time, name, got.im, want.im);
            bad++;
        end
    endtask

    task automatic compare_frame(input frame_out_t got, input frame_out_t want, output int bad);
        int lane_bad;
        bad = 0;
        for (int i = 0; i < 8; i++) begin
            compare_lane($sformatf("result[%0d]", i), got[i], want[i], lane_bad);
            bad += lane_bad;
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [4:0] draw_bits5();
        logic [4:0] v;
        for (int b = 0; b < 5; b++) begin
            v[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
        end
        return v;
    endfunction

    function automatic frame_in_t random_frame();
        frame_in_t x;
        for (int i = 0; i < 8; i++) begin
            x[i].re = draw_bits5();
            x[i].im = draw_bits5();
        end
        return x;
    endfunction

    // W8^k as (cos, -sin) times ten
    function automatic int twiddle_cos(input int k);
        case (k)
            0: return 10;
            1: return 7;
            2: return 0;
            default: return -7;
        endcase
    endfunction

    function automatic int twiddle_nsin(input int k);
        case (k)
            0: return 0;
            2: return -10;
            default: return -7;
        endcase
    endfunction

    function automatic frame_out_t fft_model(input frame_in_t x);
        int re_v [8];
        int im_v [8];
        int src;
        int span;
        int lo;
        int hi;
        int k;
        int tr;
        int ti;
        frame_out_t y;
        for (int i = 0; i < 8; i++) begin
            src = ((i & 1) << 2) | (i & 2) | ((i >> 2) & 1);  // 3-bit reverse
            re_v[i] = int'(x[src].re);
            im_v[i] = int'(x[src].im);
        end
        for (int s = 0; s < 3; s++) begin
            span = 1 << s;
            for (int g = 0; g < 8; g += 2 * span) begin
                for (int j = 0; j < span; j++) begin
                    lo = g + j;
                    hi = lo + span;
                    k  = j * (4 / span);
                    // each product divided on its own, truncating
                    tr = (re_v[hi] * twiddle_cos(k)) / 10 - (im_v[hi] * twiddle_nsin(k)) / 10;
                    ti = (re_v[hi] * twiddle_nsin(k)) / 10 + (im_v[hi] * twiddle_cos(k)) / 10;
                    re_v[hi] = re_v[lo] - tr;
                    im_v[hi] = im_v[lo] - ti;
                    re_v[lo] = re_v[lo] + tr;
                    im_v[lo] = im_v[lo] + ti;
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            y[i].re = 10'(re_v[i]);
            y[i].im = 10'(im_v[i]);
        end
        return y;
    endfunction

    task automatic drive_frame(input frame_in_t x, input frame_out_t want);
        @(posedge clk);
        sample <= x;
        exp_q.push_back(want);
        due_q.push_back(edge_cnt + 8);  // counter still holds the previous edge here
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (rd_idx < exp_q.size() && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rd_idx < exp_q.size()) begin
            $display("timeout: %s results did not all appear within 20 cycles", what);
            direct_err++;
        end
    endtask

    task automatic expect_zero_result();
        int bad;
        @(negedge clk);
        compare_frame(result, '0, bad);
        direct_err += bad;
        direct_checks++;
    endtask

    task automatic report_test(input string name, input int err_before);
        int bad;
        bad = pipe_err + direct_err - err_before;
        $display("%-20s %s, %0d errors", name, (bad == 0) ? "ok" : "failed", bad);
    endtask

    task automatic run_impulse(input int v);
        frame_in_t  x;
        frame_out_t want;
        x = '0;
        x[0].re = 5'(v);
        for (int i = 0; i < 8; i++) begin
            want[i].re = 10'(v);
            want[i].im = '0;
        end
        drive_frame(x, want);
        wait_drain("impulse");
    endtask

    task automatic run_constant(input int c, input bit imag);
        frame_in_t  x;
        frame_out_t want;
        x = '0;
        want = '0;
        for (int i = 0; i < 8; i++) begin
            if (imag) x[i].im = 5'(c);
            else      x[i].re = 5'(c);
        end
        if (imag) want[0].im = 10'(8 * c);  // all energy in bin 0
        else      want[0].re = 10'(8 * c);
        drive_frame(x, want);
        wait_drain("constant");
    endtask

    task automatic reset_values();
        int err0;
        int n;
        err0 = pipe_err + direct_err;
        n = 0;
        while (rst_n !== 1'b1 && n < 10) begin
            expect_zero_result();
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was still active after %0d cycles", n);
            direct_err++;
        end
        @(posedge clk);
        sample <= '0;  // frame taken at this edge is the first one out
        repeat (6) expect_zero_result();  // first frame not out yet
        report_test("reset", err0);
    endtask

    task automatic impulse_response();
        int err0;
        err0 = pipe_err + direct_err;
        run_impulse(1);
        run_impulse(15);
        run_impulse(-16);
        run_impulse(-5);
        report_test("impulse", err0);
    endtask

    task automatic constant_input();
        int err0;
        err0 = pipe_err + direct_err;
        run_constant(3, 1'b0);
        run_constant(-16, 1'b0);
        run_constant(15, 1'b0);
        run_constant(7, 1'b1);
        run_constant(-9, 1'b1);
        report_test("constant", err0);
    endtask

    task automatic random_held_frames();
        int err0;
        frame_in_t x;
        err0 = pipe_err + direct_err;
        for (int f = 0; f < 12; f++) begin
            x = random_frame();
            drive_frame(x, fft_model(x));
            wait_drain("random");
        end
        report_test("random held", err0);
    endtask

    task automatic back_to_back_frames();
        int err0;
        frame_in_t x;
        err0 = pipe_err + direct_err;
        for (int f = 0; f < 20; f++) begin
            x = random_frame();
            drive_frame(x, fft_model(x));
        end
        wait_drain("back-to-back");
        report_test("back to back", err0);
    endtask

    task automatic midstream_reset();
        int err0;
        frame_in_t x;
        err0 = pipe_err + direct_err;
        for (int f = 0; f < 5; f++) begin
            x = random_frame();
            drive_frame(x, fft_model(x));
        end
        repeat (4) @(posedge clk);  // first frame out while the rest are in flight
        skip_to = exp_q.size();
        sample <= '0;
        hold_reset <= 1'b1;
        expect_zero_result();
        expect_zero_result();
        @(posedge clk);
        hold_reset <= 1'b0;
        run_impulse(9);
        report_test("mid-stream reset", err0);
    endtask

    initial begin
        lfsr_state = 16'd44075;
        sample     <= random_frame();  // must not reach result through reset
        hold_reset <= 1'b0;
        reset_values();
        impulse_response();
        constant_input();
        random_held_frames();
        back_to_back_frames();
        midstream_reset();
        $display("checks %0d, errors %0d", pipe_checks + direct_checks, pipe_err + direct_err);
        if (pipe_err + direct_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/fft_num_pkg.sv
src/fft_geom_pkg.sv
src/fft_cmul_scaled.sv
src/fft_input_reorder.sv
src/fft_radix2_stage.sv
src/fft8_top.sv
tests/tb_clock_gen.sv
tests/tb_fft8.sv

//--- Makefile
TOP := tb_fft8

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module $(TOP) -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir
